// ==== Bender.yml ====
package:
  name: lsu

sources:
  - files:
      - design/lsu_pkg.sv
      - design/lsu_decode.sv
      - design/lsu_mem_access.sv
      - design/lsu_load_format.sv
      - design/lsu_top.sv
  - target: test
    files:
      - testbench/tb_mem_model.sv
      - testbench/tb_lsu_top.sv

// ==== design/lsu_decode.sv ====
`timescale 1ns/10ps

module lsu_decode (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 issue_i,
  input  lsu_pkg::lsu_instr_t  instr_i,
  output logic                 acc_valid_o,
  output lsu_pkg::lsu_access_t acc_o
);
  import lsu_pkg::*;

  logic [addr_width-1:0] addr;
  logic [1:0]            offset;
  logic                  is_store;
  size_e                 size;
  logic                  sign_ext;
  logic [strb_width-1:0] base_strb;
  logic                  bad_funct3;
  logic                  misaligned;
  lsu_access_t           acc_d;

  assign addr     = instr_i.base + instr_i.imm;
  assign offset   = addr[1:0];
  assign is_store = (instr_i.op == lsu_op_store);

  always_comb begin
    size       = size_byte;
    sign_ext   = 1'b1;
    base_strb  = 4'b0001;
    bad_funct3 = 1'b0;
    case (instr_i.funct3)
      f3_b: begin
        size = size_byte;
      end
      f3_h: begin
        size      = size_half;
        base_strb = 4'b0011;
      end
      f3_w: begin
        size      = size_word;
        base_strb = 4'b1111;
      end
      f3_bu: begin
        sign_ext   = 1'b0;
        bad_funct3 = is_store;
      end
      f3_hu: begin
        size       = size_half;
        sign_ext   = 1'b0;
        base_strb  = 4'b0011;
        bad_funct3 = is_store;
      end
      // codes 3, 6 and 7 have no load or store
      default: begin
        bad_funct3 = 1'b1;
      end
    endcase
  end

  assign misaligned = ((size == size_half) && offset[0]) ||
                      ((size == size_word) && (offset != 2'b00));

  always_comb begin
    acc_d.is_store = is_store;
    acc_d.addr     = addr;
    acc_d.size     = size;
    acc_d.sign_ext = sign_ext;
    acc_d.strb     = base_strb << offset;
    acc_d.wdata    = instr_i.store_data << {offset, 3'b000};
    // an empty op is treated as illegal too
    acc_d.fault    = bad_funct3 || misaligned || (instr_i.op == lsu_op_none);
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      acc_valid_o <= 1'b0;
    end else begin
      acc_valid_o <= issue_i;
    end
  end

  always_ff @(posedge clock) begin
    if (issue_i) begin
      acc_o <= acc_d;
    end
  end

endmodule

// ==== design/lsu_load_format.sv ====
`timescale 1ns/10ps

module lsu_load_format (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     rsp_valid_i,
  input  logic [lsu_pkg::xlen-1:0] rsp_data_i,
  input  lsu_pkg::lsu_access_t     acc_i,
  output logic                     done_o,
  output lsu_pkg::lsu_done_t       done_data_o
);
  import lsu_pkg::*;

  logic [xlen-1:0] shifted;
  logic [xlen-1:0] load_val;
  lsu_done_t       done_d;

  // addressed lane moved down to bit 0
  assign shifted = rsp_data_i >> {acc_i.addr[1:0], 3'b000};

  always_comb begin
    case (acc_i.size)
      size_byte: begin
        load_val = {{(xlen-8){acc_i.sign_ext & shifted[7]}}, shifted[7:0]};
      end
      size_half: begin
        load_val = {{(xlen-16){acc_i.sign_ext & shifted[15]}}, shifted[15:0]};
      end
      default: begin
        load_val = shifted;
      end
    endcase
  end

  always_comb begin
    done_d.result   = (acc_i.is_store || acc_i.fault) ? '0 : load_val;
    done_d.fault    = acc_i.fault;
    done_d.is_store = acc_i.is_store;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      done_o <= 1'b0;
    end else begin
      done_o <= rsp_valid_i;
    end
  end

  always_ff @(posedge clock) begin
    if (rsp_valid_i) begin
      done_data_o <= done_d;
    end
  end

endmodule

// ==== design/lsu_mem_access.sv ====
`timescale 1ns/10ps

module lsu_mem_access (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      acc_valid_i,
  input  lsu_pkg::lsu_access_t      acc_i,
  output logic                      mem_req_valid_o,
  output lsu_pkg::mem_req_t         mem_req_o,
  input  logic                      mem_req_ready_i,
  input  logic                      mem_rsp_valid_i,
  input  logic [lsu_pkg::xlen-1:0]  mem_rsp_data_i,
  output logic                      rsp_valid_o,
  output logic [lsu_pkg::xlen-1:0]  rsp_data_o,
  output lsu_pkg::lsu_access_t      acc_o,
  output logic                      busy_o
);
  import lsu_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_req,
    st_wait_rsp
  } state_e;

  state_e      state_q;
  state_e      state_d;
  lsu_access_t acc_q;
  lsu_access_t acc_cur;
  logic        start_req;
  logic        fault_now;

  // the new access is used directly in its first cycle
  assign acc_cur   = acc_valid_i ? acc_i : acc_q;
  assign fault_now = acc_valid_i && acc_i.fault;
  assign start_req = acc_valid_i && !acc_i.fault && (state_q == st_idle);

  always_comb begin
    state_d = state_q;
    case (state_q)
      st_idle: begin
        if (start_req) begin
          state_d = mem_req_ready_i ? st_wait_rsp : st_req;
        end
      end
      st_req: begin
        if (mem_req_ready_i) begin
          state_d = st_wait_rsp;
        end
      end
      st_wait_rsp: begin
        if (mem_rsp_valid_i) begin
          state_d = st_idle;
        end
      end
      default: begin
        state_d = st_idle;
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= st_idle;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clock) begin
    if (acc_valid_i) begin
      acc_q <= acc_i;
    end
  end

  // request held until the edge where ready is seen
  assign mem_req_valid_o = start_req || (state_q == st_req);

  always_comb begin
    mem_req_o.we    = acc_cur.is_store;
    mem_req_o.addr  = {acc_cur.addr[addr_width-1:2], 2'b00};
    mem_req_o.strb  = acc_cur.strb;
    mem_req_o.wdata = acc_cur.wdata;
  end

  // faults bypass the bus and complete right away
  assign rsp_valid_o = fault_now || ((state_q == st_wait_rsp) && mem_rsp_valid_i);
  assign rsp_data_o  = (state_q == st_wait_rsp) ? mem_rsp_data_i : '0;
  assign acc_o       = acc_cur;

  assign busy_o = (state_q != st_idle);

endmodule

// ==== design/lsu_pkg.sv ====
package lsu_pkg;

  localparam int xlen       = 32;
  localparam int addr_width = 32;
  localparam int strb_width = xlen / 8;

  // core side operation
  typedef enum logic [1:0] {
    lsu_op_none  = 2'd0,
    lsu_op_load  = 2'd1,
    lsu_op_store = 2'd2
  } lsu_op_e;

  typedef enum logic [1:0] {
    size_byte = 2'd0,
    size_half = 2'd1,
    size_word = 2'd2
  } size_e;

  // rv32i load/store funct3
  localparam logic [2:0] f3_b  = 3'b000;
  localparam logic [2:0] f3_h  = 3'b001;
  localparam logic [2:0] f3_w  = 3'b010;
  localparam logic [2:0] f3_bu = 3'b100;
  localparam logic [2:0] f3_hu = 3'b101;

  typedef struct packed {
    lsu_op_e               op;
    logic [2:0]            funct3;
    logic [xlen-1:0]       base;
    logic [xlen-1:0]       store_data;
    logic [xlen-1:0]       imm;
  } lsu_instr_t;

  // decoded access with wdata already in its byte lanes
  typedef struct packed {
    logic                  is_store;
    logic [addr_width-1:0] addr;
    size_e                 size;
    logic                  sign_ext;
    logic [strb_width-1:0] strb;
    logic [xlen-1:0]       wdata;
    logic                  fault;
  } lsu_access_t;

  // addr is always word aligned
  typedef struct packed {
    logic                  we;
    logic [addr_width-1:0] addr;
    logic [strb_width-1:0] strb;
    logic [xlen-1:0]       wdata;
  } mem_req_t;

  typedef struct packed {
    logic [xlen-1:0]       result;
    logic                  fault;
    logic                  is_store;
  } lsu_done_t;

endpackage

// ==== design/lsu_top.sv ====
`timescale 1ns/10ps

module lsu_top (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     issue_i,
  input  lsu_pkg::lsu_instr_t      instr_i,
  output logic                     busy_o,
  output logic                     done_o,
  output lsu_pkg::lsu_done_t       done_data_o,
  output logic                     mem_req_valid_o,
  output lsu_pkg::mem_req_t        mem_req_o,
  input  logic                     mem_req_ready_i,
  input  logic                     mem_rsp_valid_i,
  input  logic [lsu_pkg::xlen-1:0] mem_rsp_data_i
);
  import lsu_pkg::*;

  logic            acc_valid;
  lsu_access_t     acc;
  logic            rsp_valid;
  logic [xlen-1:0] rsp_data;
  lsu_access_t     fmt_acc;
  logic            mem_busy;

  lsu_decode lsu_decode_i (
    .clock       (clock),
    .reset       (reset),
    .issue_i     (issue_i),
    .instr_i     (instr_i),
    .acc_valid_o (acc_valid),
    .acc_o       (acc)
  );

  lsu_mem_access lsu_mem_access_i (
    .clock           (clock),
    .reset           (reset),
    .acc_valid_i     (acc_valid),
    .acc_i           (acc),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_o       (mem_req_o),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_rsp_valid_i (mem_rsp_valid_i),
    .mem_rsp_data_i  (mem_rsp_data_i),
    .rsp_valid_o     (rsp_valid),
    .rsp_data_o      (rsp_data),
    .acc_o           (fmt_acc),
    .busy_o          (mem_busy)
  );

  lsu_load_format lsu_load_format_i (
    .clock       (clock),
    .reset       (reset),
    .rsp_valid_i (rsp_valid),
    .rsp_data_i  (rsp_data),
    .acc_i       (fmt_acc),
    .done_o      (done_o),
    .done_data_o (done_data_o)
  );

  // decode and result stages each add a cycle around the bus FSM
  assign busy_o = acc_valid || mem_busy || done_o;

endmodule

// ==== src.f ====
design/lsu_pkg.sv
design/lsu_decode.sv
design/lsu_mem_access.sv
design/lsu_load_format.sv
design/lsu_top.sv
testbench/tb_mem_model.sv
testbench/tb_lsu_top.sv

// ==== testbench/tb_lsu_top.sv ====
`timescale 1ns/10ps

module tb_lsu_top;
  import lsu_pkg::*;

  localparam int mem_bytes  = 1024;
  localparam int idle_limit = 200;
  localparam int done_limit = 200;

  logic            clock = 1'b0;
  logic            reset;
  logic            issue;
  lsu_instr_t      instr;
  logic            busy;
  logic            done;
  lsu_done_t       done_data;
  logic            req_valid;
  mem_req_t        req;
  logic            req_ready;
  logic            rsp_valid;
  logic [xlen-1:0] rsp_data;
  int              stall_cycles;
  int              rsp_delay;

  logic [7:0]      shadow [mem_bytes];
  logic [31:0]     rng = 32'd19835;
  int              xfer_count = 0;
  int              valid_edges = 0;
  mem_req_t        last_req;
  mem_req_t        held_req;
  logic            held_valid = 1'b0;

  always #5 clock = ~clock;

  lsu_top lsu_top_i (
    .clock           (clock),
    .reset           (reset),
    .issue_i         (issue),
    .instr_i         (instr),
    .busy_o          (busy),
    .done_o          (done),
    .done_data_o     (done_data),
    .mem_req_valid_o (req_valid),
    .mem_req_o       (req),
    .mem_req_ready_i (req_ready),
    .mem_rsp_valid_i (rsp_valid),
    .mem_rsp_data_i  (rsp_data)
  );

  tb_mem_model #(.mem_bytes(mem_bytes)) mem_model_i (
    .clock       (clock),
    .reset       (reset),
    .stall_i     (stall_cycles),
    .delay_i     (rsp_delay),
    .req_valid_i (req_valid),
    .req_i       (req),
    .req_ready_o (req_ready),
    .rsp_valid_o (rsp_valid),
    .rsp_data_o  (rsp_data)
  );

  function automatic logic [31:0] xorshift32(logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic int rand_below(int n);
    rng = xorshift32(rng);
    return int'(rng % n);
  endfunction

  function automatic logic [7:0] fill_byte(int a);
    return 8'(a) ^ 8'(a >> 3) ^ 8'ha5;
  endfunction

  task automatic report_fail();
    $display("tests failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic report_timeout(string what);
    $display("timeout at %0t: %s", $time, what);
    report_fail();
  endtask

  task automatic check_flag(string name, logic exp, logic got);
    if (got !== exp) begin
      $display("[ERROR] %0t %s expected %b got %b", $time, name, exp, got);
      report_fail();
    end
  endtask

  task automatic check_count(string name, int exp, int got);
    if (got !== exp) begin
      $display("[ERROR] %0t %s expected %0d got %0d", $time, name, exp, got);
      report_fail();
    end
  endtask

  task automatic check_done(string name, lsu_done_t exp, lsu_done_t got);
    if (got !== exp) begin
      $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, got);
      report_fail();
    end
  endtask

  task automatic check_req(string name, mem_req_t exp, mem_req_t got);
    if (got !== exp) begin
      $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, got);
      report_fail();
    end
  endtask

  // bus watcher counting transfers and checking the hold rule
  always @(posedge clock) begin
    if (!reset && req_valid === 1'b1) begin
      valid_edges = valid_edges + 1;
      check_flag("busy_o", 1'b1, busy);
      if (held_valid) begin
        check_req("mem_req_o", held_req, req);
      end
      if (req_ready) begin
        xfer_count = xfer_count + 1;
        last_req   = req;
        held_valid = 1'b0;
      end else begin
        held_req   = req;
        held_valid = 1'b1;
      end
    end
  end

  task automatic wait_idle();
    int n;
    n = 0;
    while (busy !== 1'b0) begin
      @(posedge clock);
      #1;
      n = n + 1;
      if (n > idle_limit) begin
        report_timeout("busy_o never went low");
      end
    end
  endtask

  task automatic do_access(lsu_op_e op, logic [2:0] f3, logic [31:0] base,
                           logic [31:0] imm, logic [31:0] sdata, int stall);
    logic        is_store;
    logic        legal;
    logic [31:0] addr;
    logic [1:0]  off;
    logic [31:0] lanes;
    logic [31:0] raw;
    int          nbytes;
    int          lane;
    int          cycles;
    int          rsp_cycle;
    int          xfer_before;
    int          valid_before;
    lsu_done_t   exp_done;
    lsu_done_t   got_done;
    mem_req_t    exp_req;
    mem_req_t    got_req;
    addr     = base + imm;
    off      = addr[1:0];
    is_store = (op == lsu_op_store);
    nbytes   = 1 << f3[1:0];
    if (is_store) begin
      legal = f3 inside {f3_b, f3_h, f3_w};
    end else begin
      legal = f3 inside {f3_b, f3_h, f3_w, f3_bu, f3_hu};
    end
    if ((nbytes == 2 && off[0]) || (nbytes == 4 && off != 2'd0)) begin
      legal = 1'b0;
    end
    exp_done          = '0;
    exp_done.is_store = is_store;
    exp_done.fault    = !legal;
    exp_req           = '0;
    exp_req.we        = is_store;
    exp_req.addr      = {addr[31:2], 2'b00};
    lanes             = '0;
    raw               = '0;
    if (legal) begin
      for (int i = 0; i < nbytes; i++) begin
        lane                = int'(off) + i;
        exp_req.strb[lane]  = 1'b1;
        lanes[8*lane +: 8]  = 8'hff;
        raw[8*i +: 8]       = shadow[(addr + 32'(i)) % mem_bytes];
        if (is_store) begin
          exp_req.wdata[8*lane +: 8] = sdata[8*i +: 8];
        end
      end
    end
    // byte and half loads sign extend unless unsigned
    if (legal && !is_store) begin
      if (f3 == f3_b) begin
        exp_done.result = {{24{raw[7]}}, raw[7:0]};
      end else if (f3 == f3_h) begin
        exp_done.result = {{16{raw[15]}}, raw[15:0]};
      end else begin
        exp_done.result = raw;
      end
    end
    wait_idle();
    stall_cycles     = stall;
    rsp_delay        = rand_below(4);
    instr.op         = op;
    instr.funct3     = f3;
    instr.base       = base;
    instr.store_data = sdata;
    instr.imm        = imm;
    issue            = 1'b1;
    xfer_before      = xfer_count;
    valid_before     = valid_edges;
    @(posedge clock);
    #1;
    issue     = 1'b0;
    cycles    = 0;
    rsp_cycle = -1;
    do begin
      @(posedge clock);
      cycles = cycles + 1;
      if (cycles > done_limit) begin
        report_timeout("done_o never arrived");
      end
      check_flag("busy_o", 1'b1, busy);
      // a legal request comes out together with acc_valid
      if (cycles == 1) begin
        check_flag("mem_req_valid_o", legal, req_valid);
      end
      if (rsp_valid === 1'b1) begin
        rsp_cycle = cycles;
      end
    end while (done !== 1'b1);
    got_done = done_data;
    #1;
    check_done("done_data_o", exp_done, got_done);
    check_flag("done_o", 1'b0, done);
    check_flag("busy_o", 1'b0, busy);
    if (legal) begin
      check_count("request transfers", xfer_before + 1, xfer_count);
      check_count("done latency after response", rsp_cycle + 1, cycles);
      got_req = last_req;
      got_req.wdata = is_store ? (got_req.wdata & lanes) : '0;
      check_req("mem_req_o", exp_req, got_req);
    end else begin
      check_count("mem_req_valid_o cycles", valid_before, valid_edges);
      check_count("fault done latency", 2, cycles);
    end
    if (legal && is_store) begin
      for (int i = 0; i < nbytes; i++) begin
        shadow[(addr + 32'(i)) % mem_bytes] = sdata[8*i +: 8];
      end
    end
  endtask

  task automatic test_reset_state();
    check_flag("done_o", 1'b0, done);
    check_flag("busy_o", 1'b0, busy);
    check_flag("mem_req_valid_o", 1'b0, req_valid);
    do_access(lsu_op_load, f3_w, 32'h0000_0040, 32'h1, 32'h0, 0);
  endtask

  task automatic test_stores();
    for (int f = 0; f < 3; f++) begin
      for (int off = 0; off < 4; off += (1 << f)) begin
        do_access(lsu_op_store, 3'(f), 32'h100 + 32'(16 * f), 32'(off), rng, rand_below(3));
        rng = xorshift32(rng);
      end
    end
  endtask

  task automatic test_loads();
    logic [2:0] codes [5];
    codes = '{f3_b, f3_h, f3_w, f3_bu, f3_hu};
    for (int w = 0; w < 2; w++) begin
      rng = xorshift32(rng);
      do_access(lsu_op_store, f3_w, 32'h200, 32'(4 * w), rng, 0);
    end
    for (int c = 0; c < 5; c++) begin
      for (int w = 0; w < 2; w++) begin
        for (int off = 0; off < 4; off += (1 << codes[c][1:0])) begin
          do_access(lsu_op_load, codes[c], 32'h200, 32'(4 * w + off), 32'h0, rand_below(3));
        end
      end
    end
  endtask

  task automatic test_faults();
    do_access(lsu_op_load,  f3_h,  32'h300, 32'h1, 32'h0, 0);
    do_access(lsu_op_load,  f3_h,  32'h300, 32'h3, 32'h0, 0);
    do_access(lsu_op_load,  f3_hu, 32'h300, 32'h1, 32'h0, 0);
    for (int off = 1; off < 4; off++) begin
      do_access(lsu_op_load, f3_w, 32'h300, 32'(off), 32'h0, 0);
    end
    do_access(lsu_op_store, f3_h,  32'h300, 32'h1, 32'h1234_5678, 0);
    do_access(lsu_op_store, f3_w,  32'h300, 32'h2, 32'h1234_5678, 0);
    // funct3 codes with no meaning for that op
    do_access(lsu_op_load,  3'd3,  32'h300, 32'h0, 32'h0, 0);
    do_access(lsu_op_load,  3'd6,  32'h300, 32'h0, 32'h0, 0);
    do_access(lsu_op_load,  3'd7,  32'h300, 32'h0, 32'h0, 0);
    do_access(lsu_op_store, f3_bu, 32'h300, 32'h0, 32'h0, 0);
    do_access(lsu_op_store, f3_hu, 32'h300, 32'h0, 32'h0, 0);
    do_access(lsu_op_store, 3'd3,  32'h300, 32'h0, 32'h0, 0);
  endtask

  task automatic test_back_pressure();
    for (int i = 0; i < 8; i++) begin
      rng = xorshift32(rng);
      do_access(lsu_op_store, f3_w, 32'h240, 32'(4 * (i % 4)), rng, 1 + rand_below(8));
      do_access(lsu_op_load, f3_w, 32'h240, 32'(4 * (i % 4)), 32'h0, 1 + rand_below(8));
      do_access(lsu_op_load, f3_b, 32'h240, 32'(rand_below(16)), 32'h0, 1 + rand_below(8));
    end
  endtask

  task automatic test_addr_wrap();
    do_access(lsu_op_store, f3_w, 32'h0000_0004, -32'sd8, 32'hcafe_f00d, 1);
    do_access(lsu_op_load,  f3_w, 32'h0000_0004, -32'sd8, 32'h0, 2);
    do_access(lsu_op_load,  f3_b, 32'hffff_fffe, 32'h5, 32'h0, 0);
    do_access(lsu_op_store, f3_h, 32'h0000_0010, -32'sd14, 32'h0000_beef, 1);
    do_access(lsu_op_load,  f3_hu, 32'h0000_0010, -32'sd14, 32'h0, 0);
  endtask

  initial begin
    reset        = 1'b1;
    issue        = 1'b0;
    instr        = '0;
    stall_cycles = 0;
    rsp_delay    = 0;
    for (int a = 0; a < mem_bytes; a++) begin
      shadow[a] = fill_byte(a);
    end
    repeat (16) @(posedge clock);
    #1;
    reset = 1'b0;
    test_reset_state();
    test_stores();
    test_loads();
    test_faults();
    test_back_pressure();
    test_addr_wrap();
    $display("all tests passed");
    $finish;
  end

endmodule

// ==== testbench/tb_mem_model.sv ====
`timescale 1ns/10ps

module tb_mem_model #(
  parameter int mem_bytes = 1024
) (
  input  logic                     clock,
  input  logic                     reset,
  input  int                       stall_i,
  input  int                       delay_i,
  input  logic                     req_valid_i,
  input  lsu_pkg::mem_req_t        req_i,
  output logic                     req_ready_o,
  output logic                     rsp_valid_o,
  output logic [lsu_pkg::xlen-1:0] rsp_data_o
);
  import lsu_pkg::*;

  logic [7:0]      mem [mem_bytes];
  int              stalled;
  int              rsp_wait;
  logic            rsp_pending;
  logic [xlen-1:0] rsp_word;
  logic            ready_next;
  logic            rsp_next;
  logic [xlen-1:0] data_next;

  // fill pattern uses every address bit
  initial begin
    for (int a = 0; a < mem_bytes; a++) begin
      mem[a] = 8'(a) ^ 8'(a >> 3) ^ 8'ha5;
    end
    req_ready_o = 1'b0;
    rsp_valid_o = 1'b0;
    rsp_data_o  = '0;
    stalled     = 0;
    rsp_wait    = 0;
    rsp_pending = 1'b0;
    rsp_word    = '0;
  end

  always @(posedge clock) begin
    ready_next = req_ready_o;
    rsp_next   = 1'b0;
    data_next  = '0;
    if (reset) begin
      stalled     = 0;
      rsp_pending = 1'b0;
      ready_next  = 1'b0;
    end else begin
      if (rsp_pending) begin
        if (rsp_wait == 0) begin
          rsp_next    = 1'b1;
          data_next   = rsp_word;
          rsp_pending = 1'b0;
        end else begin
          rsp_wait = rsp_wait - 1;
        end
      end
      if (req_valid_i && req_ready_o) begin
        rsp_word = '0;
        for (int b = 0; b < strb_width; b++) begin
          if (req_i.we && req_i.strb[b]) begin
            mem[(req_i.addr + 32'(b)) % mem_bytes] = req_i.wdata[8*b +: 8];
          end else if (!req_i.we) begin
            rsp_word[8*b +: 8] = mem[(req_i.addr + 32'(b)) % mem_bytes];
          end
        end
        stalled = 0;
        // delay 0 answers in the cycle right after the transfer
        if (delay_i == 0) begin
          rsp_next  = 1'b1;
          data_next = rsp_word;
        end else begin
          rsp_pending = 1'b1;
          rsp_wait    = delay_i - 1;
        end
      end else if (req_valid_i) begin
        stalled = stalled + 1;
      end
      ready_next = (stalled >= stall_i);
    end
    #1;
    req_ready_o = ready_next;
    rsp_valid_o = rsp_next;
    rsp_data_o  = data_next;
  end

endmodule
